// File: Bender.yml
package:
  name: mci

sources:
  - files:
      - rtl/mci_pkg.sv
      - rtl/mci_req_port.sv
      - rtl/mci_addr_decode.sv
      - rtl/mci_csr_bank.sv
      - rtl/mci_wdt.sv
      - rtl/mci_top.sv
  - target: test
    files:
      - verif/mci_tb_clk.sv
      - verif/mci_tb.sv

// File: filelist.f
rtl/mci_pkg.sv
rtl/mci_req_port.sv
rtl/mci_addr_decode.sv
rtl/mci_csr_bank.sv
rtl/mci_wdt.sv
rtl/mci_top.sv
verif/mci_tb_clk.sv
verif/mci_tb.sv

// File: rtl/mci_addr_decode.sv
`timescale 1ns/1ps

module mci_addr_decode
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      req_valid_i,
    input  mci_req_t  req_i,
    input  mci_user_t strap_priv_user_i,
    output logic      dec_valid_o,
    output mci_dec_t  dec_o
);

    mci_reg_e csr_sel;
    logic     bad_addr;
    logic     dec_valid_q;
    mci_dec_t dec_q;

    // Word addresses only, anything else is a bad address
    always_comb begin
        bad_addr = 1'b0;
        case (req_i.addr)
            MCI_ADDR_GENERIC_OUT:    csr_sel = MCI_REG_GENERIC_OUT;
            MCI_ADDR_WDT_EN:         csr_sel = MCI_REG_WDT_EN;
            MCI_ADDR_WDT_PERIOD:     csr_sel = MCI_REG_WDT_PERIOD;
            MCI_ADDR_WDT_RESTART:    csr_sel = MCI_REG_WDT_RESTART;
            MCI_ADDR_ERR_STATUS:     csr_sel = MCI_REG_ERR_STATUS;
            MCI_ADDR_ERR_FATAL_MASK: csr_sel = MCI_REG_ERR_FATAL_MASK;
            default: begin
                csr_sel  = MCI_REG_NONE;
                bad_addr = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= req_valid_i;
        end
    end

    // Privilege decided here once, the bank trusts the flag
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            dec_q.csr      <= csr_sel;
            dec_q.write    <= req_i.write;
            dec_q.wdata    <= req_i.wdata;
            dec_q.priv     <= (req_i.user == strap_priv_user_i);
            dec_q.bad_addr <= bad_addr;
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_o       = dec_q;

endmodule

// File: rtl/mci_csr_bank.sv
`timescale 1ns/1ps

module mci_csr_bank
    import mci_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         dec_valid_i,
    input  mci_dec_t     dec_i,
    output logic         rsp_valid_o,
    output mci_rsp_t     rsp_o,

    // Watchdog control and status
    output logic         wdt_en_o,
    output mci_data_t    wdt_period_o,
    output logic         wdt_restart_o,
    input  logic         wdt_t1_i,
    input  logic         wdt_nmi_i,

    input  mci_err_vec_t agg_error_fatal_i,
    input  mci_err_vec_t agg_error_non_fatal_i,
    output mci_data_t    generic_out_o,
    output logic         all_error_fatal_o,
    output logic         all_error_non_fatal_o
);

    mci_data_t generic_out_q;
    logic      wdt_en_q;
    mci_data_t wdt_period_q;
    logic      wdt_restart_q;
    mci_data_t fatal_mask_q;
    logic      fatal_q;
    logic      non_fatal_q;
    logic      rsp_valid_q;
    mci_rsp_t  rsp_q;

    logic      priv_reg;
    logic      acc_err;
    logic      wr_en;
    mci_data_t rdata;

    ///////////////////////////////
    // Access check and readback
    ///////////////////////////////

    always_comb begin
        priv_reg = dec_i.csr inside {MCI_REG_WDT_EN, MCI_REG_WDT_PERIOD,
                                     MCI_REG_WDT_RESTART, MCI_REG_ERR_FATAL_MASK};
        acc_err  = dec_i.bad_addr || (dec_i.write && priv_reg && !dec_i.priv);
        wr_en    = dec_valid_i && dec_i.write && !acc_err;
    end

    always_comb begin
        case (dec_i.csr)
            MCI_REG_GENERIC_OUT:    rdata = generic_out_q;
            MCI_REG_WDT_EN:         rdata = mci_data_t'(wdt_en_q);
            MCI_REG_WDT_PERIOD:     rdata = wdt_period_q;
            MCI_REG_ERR_STATUS:     rdata = mci_data_t'({wdt_nmi_i, wdt_t1_i});
            MCI_REG_ERR_FATAL_MASK: rdata = fatal_mask_q;
            // Restart and unmapped addresses read zero
            default:                rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            generic_out_q <= '0;
            wdt_en_q      <= 1'b0;
            wdt_period_q  <= '0;
            wdt_restart_q <= 1'b0;
            fatal_mask_q  <= '0;
            fatal_q       <= 1'b0;
            non_fatal_q   <= 1'b0;
            rsp_valid_q   <= 1'b0;
        end else begin
            rsp_valid_q   <= dec_valid_i;
            wdt_restart_q <= 1'b0;
            fatal_q       <= |(agg_error_fatal_i & ~fatal_mask_q[MCI_ERR_W-1:0]);
            non_fatal_q   <= |agg_error_non_fatal_i;
            if (wr_en) begin
                case (dec_i.csr)
                    MCI_REG_GENERIC_OUT:    generic_out_q <= dec_i.wdata;
                    MCI_REG_WDT_EN:         wdt_en_q      <= dec_i.wdata[0];
                    MCI_REG_WDT_PERIOD:     wdt_period_q  <= dec_i.wdata;
                    MCI_REG_WDT_RESTART:    wdt_restart_q <= 1'b1;
                    MCI_REG_ERR_FATAL_MASK: fatal_mask_q  <= dec_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    // Writes return zero data
    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            rsp_q.rdata <= dec_i.write ? '0 : rdata;
            rsp_q.err   <= acc_err;
        end
    end

    assign rsp_valid_o           = rsp_valid_q;
    assign rsp_o                 = rsp_q;
    assign wdt_en_o              = wdt_en_q;
    assign wdt_period_o          = wdt_period_q;
    assign wdt_restart_o         = wdt_restart_q;
    assign generic_out_o         = generic_out_q;
    assign all_error_fatal_o     = fatal_q;
    assign all_error_non_fatal_o = non_fatal_q;

    // Refused access leaves every register as it was
    err_no_update_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_valid_o && rsp_o.err |->
            $stable({generic_out_q, wdt_en_q, wdt_period_q, fatal_mask_q}) && !wdt_restart_q);

endmodule

// File: rtl/mci_pkg.sv
package mci_pkg;

    ///////////////////////////////
    // Widths and vector types
    ///////////////////////////////

    localparam int MCI_ADDR_W = 32;
    localparam int MCI_DATA_W = 32;
    localparam int MCI_USER_W = 32;

    typedef logic [MCI_ADDR_W-1:0] mci_addr_t;
    typedef logic [MCI_DATA_W-1:0] mci_data_t;
    typedef logic [MCI_USER_W-1:0] mci_user_t;

    // Fatal and non-fatal error inputs
    localparam int MCI_ERR_W = 8;

    typedef logic [MCI_ERR_W-1:0] mci_err_vec_t;

    ///////////////////////////////
    // Register map
    ///////////////////////////////

    localparam mci_addr_t MCI_ADDR_GENERIC_OUT    = 32'h0000_0000;
    localparam mci_addr_t MCI_ADDR_WDT_EN         = 32'h0000_0004;
    localparam mci_addr_t MCI_ADDR_WDT_PERIOD     = 32'h0000_0008;
    localparam mci_addr_t MCI_ADDR_WDT_RESTART    = 32'h0000_000C;
    localparam mci_addr_t MCI_ADDR_ERR_STATUS     = 32'h0000_0010;
    localparam mci_addr_t MCI_ADDR_ERR_FATAL_MASK = 32'h0000_0014;

    typedef enum logic [2:0] {
        MCI_REG_GENERIC_OUT    = 3'd0,
        MCI_REG_WDT_EN         = 3'd1,
        MCI_REG_WDT_PERIOD     = 3'd2,
        MCI_REG_WDT_RESTART    = 3'd3,
        MCI_REG_ERR_STATUS     = 3'd4,
        MCI_REG_ERR_FATAL_MASK = 3'd5,
        MCI_REG_NONE           = 3'd7
    } mci_reg_e;

    ///////////////////////////////
    // Stage payloads
    ///////////////////////////////

    typedef struct packed {
        mci_addr_t addr;
        logic      write;
        mci_data_t wdata;
        mci_user_t user;
    } mci_req_t;

    // Decoded access, priv set when user matches the strap
    typedef struct packed {
        mci_reg_e  csr;
        logic      write;
        mci_data_t wdata;
        logic      priv;
        logic      bad_addr;
    } mci_dec_t;

    typedef struct packed {
        mci_data_t rdata;
        logic      err;
    } mci_rsp_t;

    typedef enum logic [1:0] {
        MCI_PORT_IDLE = 2'd0,
        MCI_PORT_BUSY = 2'd1,
        MCI_PORT_DONE = 2'd2
    } mci_port_state_e;

endpackage

// File: rtl/mci_req_port.sv
`timescale 1ns/1ps

module mci_req_port
    import mci_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,

    // Host side, four-phase handshake
    input  logic     req_i,
    input  mci_req_t req_data_i,
    output logic     ack_o,
    output mci_rsp_t rsp_o,

    // Pipeline side
    output logic     req_valid_o,
    output mci_req_t req_o,
    input  logic     rsp_valid_i,
    input  mci_rsp_t rsp_i
);

    mci_port_state_e state_q;
    logic            ack_q;
    logic            req_valid_q;
    mci_req_t        req_q;
    mci_rsp_t        rsp_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= MCI_PORT_IDLE;
            ack_q       <= 1'b0;
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= 1'b0;
            case (state_q)
                MCI_PORT_IDLE: begin
                    if (req_i) begin
                        req_valid_q <= 1'b1;
                        state_q     <= MCI_PORT_BUSY;
                    end
                end
                MCI_PORT_BUSY: begin
                    if (rsp_valid_i) begin
                        ack_q   <= 1'b1;
                        state_q <= MCI_PORT_DONE;
                    end
                end
                // Hold ack until the host drops req
                MCI_PORT_DONE: begin
                    if (!req_i) begin
                        ack_q   <= 1'b0;
                        state_q <= MCI_PORT_IDLE;
                    end
                end
                default: state_q <= MCI_PORT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MCI_PORT_IDLE && req_i) begin
            req_q <= req_data_i;
        end
        if (rsp_valid_i) begin
            rsp_q <= rsp_i;
        end
    end

    assign ack_o       = ack_q;
    assign rsp_o       = rsp_q;
    assign req_valid_o = req_valid_q;
    assign req_o       = req_q;

    ///////////////////////////////
    // Assertions
    ///////////////////////////////

    ack_needs_req_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(ack_o) |-> req_i);

    // Pipeline answers only the request in flight
    rsp_in_busy_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_valid_i |-> state_q == MCI_PORT_BUSY);

endmodule

// File: rtl/mci_top.sv
`timescale 1ns/1ps

module mci_top
    import mci_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         req_i,
    input  mci_req_t     req_data_i,
    output logic         ack_o,
    output mci_rsp_t     rsp_o,
    input  mci_user_t    strap_priv_user_i,
    input  mci_err_vec_t agg_error_fatal_i,
    input  mci_err_vec_t agg_error_non_fatal_i,
    output mci_data_t    generic_out_o,
    output logic         mci_intr_o,
    output logic         nmi_o,
    output logic         all_error_fatal_o,
    output logic         all_error_non_fatal_o
);

    logic      req_valid;
    mci_req_t  req;
    logic      dec_valid;
    mci_dec_t  dec;
    logic      rsp_valid;
    mci_rsp_t  rsp;
    logic      wdt_en;
    mci_data_t wdt_period;
    logic      wdt_restart;

    mci_req_port i_mci_req_port (
        .clk, .rst_n_i, .req_i, .req_data_i, .ack_o, .rsp_o,
        .req_valid_o(req_valid), .req_o(req), .rsp_valid_i(rsp_valid), .rsp_i(rsp)
    );

    mci_addr_decode i_mci_addr_decode (
        .clk, .rst_n_i, .req_valid_i(req_valid), .req_i(req), .strap_priv_user_i,
        .dec_valid_o(dec_valid), .dec_o(dec)
    );

    // CSR bank, t1 doubles as the MCU interrupt
    mci_csr_bank i_mci_csr_bank (
        .clk, .rst_n_i, .dec_valid_i(dec_valid), .dec_i(dec),
        .rsp_valid_o(rsp_valid), .rsp_o(rsp),
        .wdt_en_o(wdt_en), .wdt_period_o(wdt_period), .wdt_restart_o(wdt_restart),
        .wdt_t1_i(mci_intr_o), .wdt_nmi_i(nmi_o),
        .agg_error_fatal_i, .agg_error_non_fatal_i, .generic_out_o,
        .all_error_fatal_o, .all_error_non_fatal_o
    );

    mci_wdt i_mci_wdt (
        .clk, .rst_n_i, .en_i(wdt_en), .period_i(wdt_period), .restart_i(wdt_restart),
        .t1_timeout_o(mci_intr_o), .nmi_o
    );

endmodule

// File: rtl/mci_wdt.sv
`timescale 1ns/1ps

module mci_wdt
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      en_i,
    input  mci_data_t period_i,
    input  logic      restart_i,
    output logic      t1_timeout_o,
    output logic      nmi_o
);

    mci_data_t cnt_q;
    logic      t1_q;
    logic      nmi_q;

    ///////////////////////////////
    // Two-stage timer
    ///////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            t1_q  <= 1'b0;
            nmi_q <= 1'b0;
        end else if (restart_i) begin
            // Service clears the first stage only
            cnt_q <= '0;
            t1_q  <= 1'b0;
        end else if (!en_i) begin
            cnt_q <= '0;
        end else if (cnt_q == period_i) begin
            cnt_q <= '0;
            if (t1_q) begin
                nmi_q <= 1'b1;
            end else begin
                t1_q <= 1'b1;
            end
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign t1_timeout_o = t1_q;
    assign nmi_o        = nmi_q;

    // Second expiry only after an unserviced first one
    nmi_after_t1_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(nmi_o) |-> $past(t1_timeout_o));

endmodule

// File: verif/mci_tb.sv
`timescale 1ns/1ps

module mci_tb
    import mci_pkg::*;
();

    localparam int N_RANDOM = 200;
    // About 300 transactions of 15 cycles plus watchdog waits and margin
    localparam int MAX_CYCLES = 4 * (300 * 15) + 2000;

    logic         clk;
    logic         rst_n;
    logic         req;
    mci_req_t     req_data;
    logic         ack;
    mci_rsp_t     rsp;
    mci_user_t    strap_user;
    mci_err_vec_t err_fatal;
    mci_err_vec_t err_non_fatal;
    mci_data_t    generic_out;
    logic         intr;
    logic         nmi;
    logic         all_fatal;
    logic         all_non_fatal;

    // Reference register state
    mci_data_t    m_generic;
    logic         m_wdt_en;
    mci_data_t    m_wdt_period;
    mci_data_t    m_fatal_mask;

    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;

    mci_tb_clk clk_gen_i (.clk_o(clk));

    mci_top dut_i (
        .clk(clk), .rst_n_i(rst_n), .req_i(req), .req_data_i(req_data),
        .ack_o(ack), .rsp_o(rsp), .strap_priv_user_i(strap_user),
        .agg_error_fatal_i(err_fatal), .agg_error_non_fatal_i(err_non_fatal),
        .generic_out_o(generic_out), .mci_intr_o(intr), .nmi_o(nmi),
        .all_error_fatal_o(all_fatal), .all_error_non_fatal_o(all_non_fatal)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles before the tests finished", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////
    // Checks and reporting
    //////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    //////////////////////////////
    // Host side and model
    //////////////////////////////

    task automatic host_access(input mci_req_t r, output mci_rsp_t got);
        @(posedge clk);
        req      <= 1'b1;
        req_data <= r;
        do begin
            @(negedge clk);
        end while (!ack);
        got = rsp;
        @(posedge clk);
        req <= 1'b0;
        do begin
            @(negedge clk);
        end while (ack);
    endtask

    task automatic model_access(input mci_req_t r, output mci_rsp_t exp);
        logic priv;
        logic priv_reg;
        logic known;
        priv     = (r.user == strap_user);
        priv_reg = r.addr inside {MCI_ADDR_WDT_EN, MCI_ADDR_WDT_PERIOD,
                                  MCI_ADDR_WDT_RESTART, MCI_ADDR_ERR_FATAL_MASK};
        known    = priv_reg || r.addr inside {MCI_ADDR_GENERIC_OUT, MCI_ADDR_ERR_STATUS};
        exp      = '0;
        if (!known || (r.write && priv_reg && !priv)) begin
            exp.err = 1'b1;
        end else if (r.write) begin
            // Writes answer with zero data
            case (r.addr)
                MCI_ADDR_GENERIC_OUT:    m_generic    = r.wdata;
                MCI_ADDR_WDT_EN:         m_wdt_en     = r.wdata[0];
                MCI_ADDR_WDT_PERIOD:     m_wdt_period = r.wdata;
                MCI_ADDR_ERR_FATAL_MASK: m_fatal_mask = r.wdata;
                default: ;
            endcase
        end else begin
            case (r.addr)
                MCI_ADDR_GENERIC_OUT:    exp.rdata = m_generic;
                MCI_ADDR_WDT_EN:         exp.rdata = {31'b0, m_wdt_en};
                MCI_ADDR_WDT_PERIOD:     exp.rdata = m_wdt_period;
                MCI_ADDR_ERR_FATAL_MASK: exp.rdata = m_fatal_mask;
                // Status stays 0 as the watchdog never runs in the random phase
                default:                 exp.rdata = '0;
            endcase
        end
    endtask

    task automatic run_access(input mci_req_t r);
        mci_rsp_t exp;
        mci_rsp_t got;
        model_access(r, exp);
        host_access(r, got);
        compare_value("rsp_o.rdata", got.rdata, exp.rdata);
        compare_value("rsp_o.err", got.err, exp.err);
        if (r.write) begin
            compare_value("generic_out_o", generic_out, m_generic);
        end
    endtask

    function automatic mci_req_t make_req(input mci_addr_t addr, input logic write,
                                          input mci_data_t wdata);
        mci_req_t r;
        r.addr  = addr;
        r.write = write;
        r.wdata = wdata;
        r.user  = strap_user;
        return r;
    endfunction

    function automatic mci_req_t random_req();
        mci_req_t r;
        if ($urandom_range(0, 9) < 8) begin
            r.addr = mci_addr_t'($urandom_range(0, 5) * 4);
        end else begin
            r.addr = mci_addr_t'(32'h18 + $urandom_range(0, 255));
        end
        r.write = $urandom_range(0, 1);
        r.wdata = $urandom;
        r.user  = $urandom_range(0, 1) ? strap_user : strap_user ^ ($urandom | 32'h1);
        // Keep the watchdog disabled
        if (r.addr == MCI_ADDR_WDT_EN) begin
            r.wdata[0] = 1'b0;
        end
        return r;
    endfunction

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        mci_rsp_t got;
        int       start;
        void'($urandom(1));
        rst_n         = 1'b0;
        req           = 1'b0;
        req_data      = '0;
        err_fatal     = '0;
        err_non_fatal = '0;
        strap_user    = $urandom;
        m_generic     = '0;
        m_wdt_en      = 1'b0;
        m_wdt_period  = '0;
        m_fatal_mask  = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        compare_value("ack_o", ack, 0);
        compare_value("generic_out_o", generic_out, 0);
        compare_value("mci_intr_o", intr, 0);
        compare_value("nmi_o", nmi, 0);
        compare_value("all_error_fatal_o", all_fatal, 0);
        compare_value("all_error_non_fatal_o", all_non_fatal, 0);

        for (int i = 0; i < N_RANDOM; i++) begin
            run_access(random_req());
        end

        // Error aggregation under a few random masks
        for (int k = 0; k < 4; k++) begin
            run_access(make_req(MCI_ADDR_ERR_FATAL_MASK, 1'b1, $urandom));
            for (int j = 0; j < 8; j++) begin
                @(posedge clk);
                err_fatal     <= mci_err_vec_t'($urandom & $urandom);
                err_non_fatal <= ($urandom_range(0, 3) == 0) ? '0 : mci_err_vec_t'($urandom);
                repeat (2) @(posedge clk);
                @(negedge clk);
                compare_value("all_error_fatal_o", all_fatal,
                              |(err_fatal & ~m_fatal_mask[MCI_ERR_W-1:0]));
                compare_value("all_error_non_fatal_o", all_non_fatal, |err_non_fatal);
            end
        end

        // Watchdog first stage and service
        run_access(make_req(MCI_ADDR_WDT_PERIOD, 1'b1, 32'd20));
        run_access(make_req(MCI_ADDR_WDT_EN, 1'b1, 32'd1));
        start = cycles;
        do begin
            host_access(make_req(MCI_ADDR_ERR_STATUS, 1'b0, '0), got);
        end while (!got.rdata[0] && cycles - start < 40);
        if (!got.rdata[0]) begin
            report_error("watchdog interrupt did not set within 40 cycles of enable");
        end
        compare_value("mci_intr_o", intr, 1);
        compare_value("ERR_STATUS nmi bit", got.rdata[1], 0);
        run_access(make_req(MCI_ADDR_WDT_RESTART, 1'b1, '0));
        repeat (15) begin
            @(negedge clk);
            compare_value("mci_intr_o", intr, 0);
        end

        // Second expiry without service raises the NMI
        start = cycles;
        while (!intr && cycles - start < 40) @(negedge clk);
        if (!intr) begin
            report_error("watchdog interrupt did not set again after the restart");
        end
        start = cycles;
        while (!nmi && cycles - start < 60) @(negedge clk);
        if (!nmi) begin
            report_error("NMI did not set within 60 cycles of the interrupt");
        end
        run_access(make_req(MCI_ADDR_WDT_RESTART, 1'b1, '0));
        compare_value("nmi_o", nmi, 1);
        compare_value("mci_intr_o", intr, 0);
        host_access(make_req(MCI_ADDR_ERR_STATUS, 1'b0, '0), got);
        compare_value("ERR_STATUS", got.rdata, 32'h2);
        compare_value("rsp_o.err", got.err, 0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verif/mci_tb_clk.sv
`timescale 1ns/1ps

module mci_tb_clk (
    output logic clk_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

endmodule
